// File: src/core_types_pkg.sv
// Core-wide widths and payload types for the immediate ALU pipeline.
// Bank, tag and ROB widths are fixed for the whole back end.
// Op codes follow the RISC-V funct3 of the I-type ALU ops.
// The top bit of the op marks the arithmetic right shift.

package core_types_pkg;

  // Register file banking
  localparam int PRF_BANK_COUNT = 2;
  localparam int LOG_PRF_BANK_COUNT = 1;

  // Physical register tag and ROB index widths
  localparam int LOG_PR_COUNT = 7;
  localparam int LOG_ROB_ENTRIES = 6;

  // Codes outside this list compute as ADDI
  typedef enum logic [3:0] {
    ADDI  = 4'b0000,
    SLLI  = 4'b0001,
    SLTI  = 4'b0010,
    SLTIU = 4'b0011,
    XORI  = 4'b0100,
    SRLI  = 4'b0101,
    ORI   = 4'b0110,
    ANDI  = 4'b0111,
    SRAI  = 4'b1101
  } alu_imm_op_t;

  // Issued instruction, 32 bits
  typedef struct packed {
    alu_imm_op_t                  op;
    logic [11:0]                  imm12;
    logic                         A_forward;
    logic                         A_is_zero;
    logic [LOG_PRF_BANK_COUNT-1:0] A_bank;
    logic [LOG_PR_COUNT-1:0]      dest_pr;
    logic [LOG_ROB_ENTRIES-1:0]   rob_index;
  } issue_t;

  // Operand-collect to execute payload
  typedef struct packed {
    alu_imm_op_t                op;
    logic [11:0]                imm12;
    logic [31:0]                operand_a;
    logic [LOG_PR_COUNT-1:0]    pr;
    logic [LOG_ROB_ENTRIES-1:0] rob_index;
  } exec_t;

  // Writeback payload, 45 bits
  typedef struct packed {
    logic [31:0]                data;
    logic [LOG_PR_COUNT-1:0]    pr;
    logic [LOG_ROB_ENTRIES-1:0] rob_index;
  } wb_t;

endpackage

// File: src/alu_imm_ctrl.sv
// Stage valid bits and advance decisions for the OC, EX and WB stages.
// The advance chain runs backwards from the WB handshake, so
// issue_ready combinationally depends on WB_ready and operand_ready.
// issue_ready is not gated by reset; it is high whenever OC is empty.

module alu_imm_ctrl (
  input  logic CLK,
  input  logic nRST,
  input  logic issue_valid,
  output logic issue_ready,
  input  logic operand_ready,
  input  logic WB_ready,
  output logic WB_valid,
  output logic oc_load,
  output logic ex_load,
  output logic wb_load,
  output logic operand_clear
);

  logic oc_valid;
  logic ex_valid;
  logic wb_free;
  logic ex_free;
  logic oc_advance;

  // WB stage can take a new result when empty or its result is taken
  assign wb_free = !WB_valid || WB_ready;
  assign wb_load = ex_valid && wb_free;

  // EX frees up when empty or moving into WB
  assign ex_free = !ex_valid || wb_free;
  assign ex_load = oc_valid && operand_ready && ex_free;

  // OC only leaves once its operand is in hand
  assign oc_advance = ex_load;
  assign issue_ready = !oc_valid || oc_advance;
  assign oc_load = issue_valid && issue_ready;

  // Drop any held operand as the instruction leaves OC
  assign operand_clear = oc_advance;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      oc_valid <= 1'b0;
      ex_valid <= 1'b0;
      WB_valid <= 1'b0;
    end else begin
      if (oc_load) begin
        oc_valid <= 1'b1;
      end else if (oc_advance) begin
        oc_valid <= 1'b0;
      end

      if (ex_load) begin
        ex_valid <= 1'b1;
      end else if (wb_load) begin
        ex_valid <= 1'b0;
      end

      // WB holds its result until the consumer takes it
      if (wb_load) begin
        WB_valid <= 1'b1;
      end else if (WB_ready) begin
        WB_valid <= 1'b0;
      end
    end
  end

endmodule

// File: src/operand_select.sv
// Operand-collect stage: holds the issued instruction and gathers A.
// Forward data is valid only in the first OC cycle; read data only
// in the cycle its ack is high. Either is kept in a hold register
// if the instruction cannot leave OC in that cycle.

module operand_select (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        oc_load,
  input  logic                        operand_clear,
  input  core_types_pkg::issue_t      issue,
  input  logic                        A_reg_read_ack,
  input  logic                        A_reg_read_port,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]      forward_data_by_bank,
  output logic                        operand_ready,
  output core_types_pkg::exec_t       oc_out
);

  core_types_pkg::issue_t oc_q;
  logic        fresh;
  logic        have_operand;
  logic [31:0] held_a;
  logic [31:0] live_a;
  logic        live_valid;
  logic        capture;

  // Instruction payload
  always_ff @(posedge CLK) begin
    if (oc_load) begin
      oc_q <= issue;
    end
  end

  // Forwarded A only exists in the first cycle after load
  assign live_a = oc_q.A_forward ? forward_data_by_bank[oc_q.A_bank]
                                 : reg_read_data_by_bank_by_port[oc_q.A_bank][A_reg_read_port];
  assign live_valid = oc_q.A_forward ? fresh : A_reg_read_ack;
  assign capture = !have_operand && !oc_q.A_is_zero && live_valid;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      fresh <= 1'b0;
      have_operand <= 1'b0;
    end else begin
      fresh <= oc_load;
      if (operand_clear || oc_load) begin
        have_operand <= 1'b0;
      end else if (capture) begin
        have_operand <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      held_a <= live_a;
    end
  end

  assign operand_ready = oc_q.A_is_zero || have_operand || live_valid;

  always_comb begin
    oc_out.op = oc_q.op;
    oc_out.imm12 = oc_q.imm12;
    oc_out.pr = oc_q.dest_pr;
    oc_out.rob_index = oc_q.rob_index;
    if (oc_q.A_is_zero) begin
      oc_out.operand_a = 32'd0;
    end else if (have_operand) begin
      oc_out.operand_a = held_a;
    end else begin
      oc_out.operand_a = live_a;
    end
  end

endmodule

// File: src/alu_imm_exec.sv
// Execute stage register, immediate ALU and writeback output register.
// The immediate is sign-extended to 32 bits; shifts use imm12[4:0].
// Op codes outside the defined set compute as ADDI.
// wb only changes on wb_load, so it holds while the consumer stalls.

module alu_imm_exec (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  ex_load,
  input  logic                  wb_load,
  input  core_types_pkg::exec_t oc_out,
  output core_types_pkg::wb_t   wb
);

  core_types_pkg::exec_t ex_q;
  logic [31:0] imm_sext;
  logic [4:0]  shamt;
  logic [31:0] alu_result;

  always_ff @(posedge CLK) begin
    if (ex_load) begin
      ex_q <= oc_out;
    end
  end

  assign imm_sext = {{20{ex_q.imm12[11]}}, ex_q.imm12};
  assign shamt = ex_q.imm12[4:0];

  always_comb begin
    case (ex_q.op)
      core_types_pkg::SLLI: begin
        alu_result = ex_q.operand_a << shamt;
      end
      core_types_pkg::SLTI: begin
        alu_result = {31'd0, $signed(ex_q.operand_a) < $signed(imm_sext)};
      end
      core_types_pkg::SLTIU: begin
        alu_result = {31'd0, ex_q.operand_a < imm_sext};
      end
      core_types_pkg::XORI: begin
        alu_result = ex_q.operand_a ^ imm_sext;
      end
      core_types_pkg::SRLI: begin
        alu_result = ex_q.operand_a >> shamt;
      end
      core_types_pkg::ORI: begin
        alu_result = ex_q.operand_a | imm_sext;
      end
      core_types_pkg::ANDI: begin
        alu_result = ex_q.operand_a & imm_sext;
      end
      core_types_pkg::SRAI: begin
        alu_result = $unsigned($signed(ex_q.operand_a) >>> shamt);
      end
      default: begin
        // ADDI and any unused code
        alu_result = ex_q.operand_a + imm_sext;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wb <= '0;
    end else if (wb_load) begin
      wb.data <= alu_result;
      wb.pr <= ex_q.pr;
      wb.rob_index <= ex_q.rob_index;
    end
  end

endmodule

// File: src/alu_imm_pipeline.sv
// Immediate ALU pipeline: OC, EX and WB registers, one issue per cycle.
// With A ready in the first OC cycle and no WB stall, a result is
// presented three edges after its issue is accepted.
// The register file and forward network are outside this block.
// Results leave in issue order.

module alu_imm_pipeline (
  input  logic                   CLK,
  input  logic                   nRST,

  // Issue
  input  logic                   issue_valid,
  input  core_types_pkg::issue_t issue,
  output logic                   issue_ready,

  // Register read and forwarding
  input  logic                   A_reg_read_ack,
  input  logic                   A_reg_read_port,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]      forward_data_by_bank,

  // Writeback
  output logic                   WB_valid,
  output core_types_pkg::wb_t    wb,
  input  logic                   WB_ready
);

  logic operand_ready;
  logic oc_load;
  logic ex_load;
  logic wb_load;
  logic operand_clear;
  core_types_pkg::exec_t oc_out;

  alu_imm_ctrl u_ctrl (
    .CLK           (CLK),
    .nRST          (nRST),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .operand_ready (operand_ready),
    .WB_ready      (WB_ready),
    .WB_valid      (WB_valid),
    .oc_load       (oc_load),
    .ex_load       (ex_load),
    .wb_load       (wb_load),
    .operand_clear (operand_clear)
  );

  operand_select u_operand_select (
    .CLK                           (CLK),
    .nRST                          (nRST),
    .oc_load                       (oc_load),
    .operand_clear                 (operand_clear),
    .issue                         (issue),
    .A_reg_read_ack                (A_reg_read_ack),
    .A_reg_read_port               (A_reg_read_port),
    .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
    .forward_data_by_bank          (forward_data_by_bank),
    .operand_ready                 (operand_ready),
    .oc_out                        (oc_out)
  );

  alu_imm_exec u_exec (
    .CLK     (CLK),
    .nRST    (nRST),
    .ex_load (ex_load),
    .wb_load (wb_load),
    .oc_out  (oc_out),
    .wb      (wb)
  );

endmodule

// File: tests/alu_imm_pipeline_assertions.sv
// Concurrent checks on the writeback handshake and the fixed latency.
// The latency check only covers zero or forwarded A with WB_ready high
// for the whole flight of the instruction.

module alu_imm_pipeline_assertions (
  input logic                   CLK,
  input logic                   nRST,
  input logic                   issue_valid,
  input logic                   issue_ready,
  input core_types_pkg::issue_t issue,
  input logic                   WB_valid,
  input logic                   WB_ready,
  input core_types_pkg::wb_t    wb
);
  timeunit 1ns;
  timeprecision 1ps;

  logic fast_accept;

  // Accepted with an operand that needs no register read
  assign fast_accept = issue_valid && issue_ready && (issue.A_is_zero || issue.A_forward);

  // A stalled result must not move
  wb_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (WB_valid && !WB_ready) |=> (WB_valid && $stable(wb)))
    else $error("WB output changed while stalled");

  // First cycle out of reset has nothing to write back
  wb_idle_after_reset: assert property (@(posedge CLK)
    $rose(nRST) |-> !WB_valid)
    else $error("WB_valid high right after reset");

  // Three stages and no stall, so the tag comes out three edges after acceptance
  wb_latency_tag: assert property (@(posedge CLK) disable iff (!nRST)
    ($past(fast_accept, 3) && $past(WB_ready, 2) && $past(WB_ready, 1))
    |-> (WB_valid && wb.pr == $past(issue.dest_pr, 3)
      && wb.rob_index == $past(issue.rob_index, 3)))
    else $error("WB tag does not match the instruction issued three cycles earlier");

endmodule

// File: tests/tb_alu_imm_pipeline.sv
// Testbench for the immediate ALU pipeline.
// Models the forward bus and the register file read ports.
// Runs four phases: every op with zero A, mixed operand sources with ack
// delays, back-to-back streaming, and random writeback stalls.

module tb_alu_imm_pipeline;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 8;
  localparam int N_OPS = 36;
  localparam int N_MIXED = 60;
  localparam int N_STREAM = 40;
  localparam int N_STALL = 80;
  localparam int TOTAL = N_OPS + N_MIXED + N_STREAM + N_STALL;
  localparam int WATCHDOG_NS = (TOTAL * 40 + RESET_CYCLES + 4) * 100;
  localparam int NB = core_types_pkg::PRF_BANK_COUNT;

  logic CLK;
  logic nRST;
  logic issue_valid;
  logic issue_ready;
  core_types_pkg::issue_t issue;
  logic A_reg_read_ack;
  logic A_reg_read_port;
  logic [NB-1:0][1:0][31:0] reg_read_data_by_bank_by_port;
  logic [NB-1:0][31:0] forward_data_by_bank;
  logic WB_valid;
  core_types_pkg::wb_t wb;
  logic WB_ready;

  logic [31:0] rng_state = 32'h32d7c080;
  int phase = 0;
  int phase_total = 0;
  int gen_count = 0;
  int cycle = 0;
  bit saw_ready_low = 0;
  core_types_pkg::wb_t exp_q[$];
  int accept_cycle_q[$];

  // Instruction waiting on the issue port and where its A comes from (0 zero, 1 forward, 2 read)
  int nxt_src;
  logic [31:0] nxt_a;
  logic nxt_port;
  int nxt_delay;

  // Register read model for the instruction in OC
  bit rd_pending = 0;
  int rd_count;
  logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] rd_bank;
  logic rd_port;
  logic [31:0] rd_a;

  alu_imm_pipeline u_alu_imm_pipeline (.*);

  bind alu_imm_pipeline alu_imm_pipeline_assertions u_assertions (
    .CLK(CLK), .nRST(nRST), .issue_valid(issue_valid), .issue_ready(issue_ready),
    .issue(issue), .WB_valid(WB_valid), .WB_ready(WB_ready), .wb(wb)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic core_types_pkg::alu_imm_op_t op_by_index(input int idx);
    case (idx)
      0: return core_types_pkg::ADDI;
      1: return core_types_pkg::SLLI;
      2: return core_types_pkg::SLTI;
      3: return core_types_pkg::SLTIU;
      4: return core_types_pkg::XORI;
      5: return core_types_pkg::SRLI;
      6: return core_types_pkg::ORI;
      7: return core_types_pkg::ANDI;
      default: return core_types_pkg::SRAI;
    endcase
  endfunction

  // Expected writeback from the ISA rules
  function automatic core_types_pkg::wb_t alu_imm_ref(
    input core_types_pkg::alu_imm_op_t op, input logic [11:0] imm12, input logic [31:0] a,
    input logic [core_types_pkg::LOG_PR_COUNT-1:0] pr,
    input logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] rob);
    core_types_pkg::wb_t r;
    logic [31:0] imm;
    logic [4:0] sh;
    imm = {{20{imm12[11]}}, imm12};
    sh = imm12[4:0];
    case (op)
      core_types_pkg::SLLI: r.data = a << sh;
      core_types_pkg::SLTI: r.data = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
      core_types_pkg::SLTIU: r.data = (a < imm) ? 32'd1 : 32'd0;
      core_types_pkg::XORI: r.data = a ^ imm;
      core_types_pkg::SRLI: r.data = a >> sh;
      core_types_pkg::ORI: r.data = a | imm;
      core_types_pkg::ANDI: r.data = a & imm;
      core_types_pkg::SRAI: r.data = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
      default: r.data = a + imm;
    endcase
    r.pr = pr;
    r.rob_index = rob;
    return r;
  endfunction

  // Corner values now and then to hit sign handling
  function automatic logic [31:0] draw_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[2:0])
      3'd0: return 32'h8000_0000;
      3'd1: return 32'hffff_ffff;
      3'd2: return 32'h7fff_ffff;
      default: return next_rand();
    endcase
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_wb(input string name, input core_types_pkg::wb_t got,
                          input core_types_pkg::wb_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic make_instruction();
    core_types_pkg::issue_t ins;
    logic [31:0] r;
    r = next_rand();
    if (phase == 2) begin
      ins.op = op_by_index(gen_count % 9);
      nxt_src = 0;
    end else begin
      // Unused codes must behave as ADDI
      ins.op = (r[3:0] == 4'd0) ? core_types_pkg::alu_imm_op_t'(4'b1010)
                                : op_by_index((r >> 8) % 9);
      nxt_src = (r >> 16) % 3;
    end
    nxt_delay = (phase == 4) ? 0 : (r >> 20) % 4;
    nxt_a = (nxt_src == 0) ? 32'd0 : draw_operand();
    r = next_rand();
    nxt_port = r[0];
    ins.imm12 = r[12:1];
    ins.A_is_zero = (nxt_src == 0);
    ins.A_forward = (nxt_src == 1);
    ins.A_bank = r[13];
    ins.dest_pr = r[20:14];
    ins.rob_index = r[26:21];
    issue <= ins;
  endtask

  // Stimulus and operand source model
  always @(posedge CLK) begin
    bit accepted;
    bit give;
    logic [31:0] r;
    accepted = issue_valid && issue_ready;
    if (nRST) begin
      if (accepted) begin
        exp_q.push_back(alu_imm_ref(issue.op, issue.imm12, nxt_a, issue.dest_pr,
                                    issue.rob_index));
        accept_cycle_q.push_back(cycle);
        rd_pending = (nxt_src == 2);
        rd_count = nxt_delay;
        rd_bank = issue.A_bank;
        rd_port = nxt_port;
        rd_a = nxt_a;
      end
      for (int b = 0; b < NB; b++) begin
        forward_data_by_bank[b] <= next_rand();
        reg_read_data_by_bank_by_port[b][0] <= next_rand();
        reg_read_data_by_bank_by_port[b][1] <= next_rand();
      end
      // Forward data lives only in the first OC cycle
      if (accepted && nxt_src == 1) begin
        forward_data_by_bank[issue.A_bank] <= nxt_a;
      end
      give = rd_pending && rd_count == 0;
      if (rd_pending) begin
        if (rd_count == 0) begin
          rd_pending = 0;
        end else begin
          rd_count--;
        end
      end
      A_reg_read_ack <= give;
      if (give) begin
        A_reg_read_port <= rd_port;
      end else begin
        r = next_rand();
        A_reg_read_port <= r[31];
      end
      if (give) begin
        reg_read_data_by_bank_by_port[rd_bank][rd_port] <= rd_a;
      end
      WB_ready <= (phase == 5) ? ((next_rand() >> 8) % 10 >= 4) : 1'b1;
      if (!issue_valid || issue_ready) begin
        if (gen_count < phase_total && (phase == 4 || (next_rand() >> 8) % 8 != 0)) begin
          make_instruction();
          issue_valid <= 1'b1;
          gen_count++;
        end else begin
          issue_valid <= 1'b0;
        end
      end
      if (phase == 5 && !issue_ready) begin
        saw_ready_low = 1;
      end
      if (phase == 4 && issue_valid) begin
        check_bit("issue_ready", issue_ready, 1'b1);
      end
    end
  end

  always @(posedge CLK) begin
    cycle <= cycle + 1;
  end

  // Scoreboard
  always @(posedge CLK) begin
    core_types_pkg::wb_t exp;
    int lat;
    if (nRST && WB_valid && WB_ready) begin
      if (exp_q.size() == 0) begin
        report_failure("a result came out with no instruction outstanding");
      end else begin
        exp = exp_q.pop_front();
        lat = cycle - accept_cycle_q.pop_front();
        check_wb("wb", wb, exp);
        if (phase == 4 && lat != 3) begin
          report_failure($sformatf("mismatch latency: got %h expected %h", lat, 3));
        end
      end
    end
  end

  task automatic run_phase(input int id, input int count);
    @(negedge CLK);
    gen_count = 0;
    phase_total = count;
    phase = id;
    do begin
      @(negedge CLK);
    end while (gen_count < phase_total || issue_valid || exp_q.size() != 0);
  endtask

  initial begin
    #(WATCHDOG_NS * 1ns);
    $display("Run timed out before all results were written back");
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    nRST = 1'b0;
    issue_valid = 1'b0;
    issue = '0;
    A_reg_read_ack = 1'b0;
    A_reg_read_port = 1'b0;
    reg_read_data_by_bank_by_port = '0;
    forward_data_by_bank = '0;
    WB_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_bit("WB_valid", WB_valid, 1'b0);
    check_bit("issue_ready", issue_ready, 1'b1);
    run_phase(2, N_OPS);
    run_phase(3, N_MIXED);
    run_phase(4, N_STREAM);
    run_phase(5, N_STALL);
    check_bit("issue_ready_fell", saw_ready_low, 1'b1);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: alu_imm_pipeline.f
src/core_types_pkg.sv
src/alu_imm_ctrl.sv
src/operand_select.sv
src/alu_imm_exec.sv
src/alu_imm_pipeline.sv
tests/alu_imm_pipeline_assertions.sv
tests/tb_alu_imm_pipeline.sv

// File: Makefile
# Verilator build and run for the immediate ALU pipeline

VERILATOR  ?= verilator
TOP        := tb_alu_imm_pipeline
RTL_TOP    := alu_imm_pipeline
FILELIST   := alu_imm_pipeline.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
